// ==== Makefile ====
# Verilator build, run, lint and clean for the MIDI sound core testbench

VERILATOR ?= verilator
TOP ?= gb_midi_tb
DUT_TOP ?= gb_midi_top
FILELIST ?= sim.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only --timing -Wall --timescale 1ns/100ps
SIM_ARGS ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim.f ====
+incdir+verilog
verilog/gb_midi_pkg.sv
verilog/clock_enables.sv
verilog/midi_uart_rx.sv
verilog/midi_note_parser.sv
verilog/patch_preset_loader.sv
verilog/fm_output_stage.sv
verilog/gb_midi_top.sv
verif/gb_midi_asserts.sv
verif/gb_midi_tb.sv

// ==== verif/gb_midi_asserts.sv ====
//**************************************************************************
// Concurrent checks bound into the sound core top level: one-cycle
// strobes, FM enable spacing and the output state after reset
//**************************************************************************
`default_nettype none

module gb_midi_asserts (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic ce_pix,
	input wire logic ce_slow,
	input wire logic fm_ce,
	input wire logic rx_valid,
	input wire logic note_gate,
	input wire logic load_valid,
	input wire logic [31:0] audio_out
);

	timeunit 1ns;
	timeprecision 100ps;

	// Read by the testbench summary
	int fail_count = 0;

	a_pix_single: assert property (@(posedge clk_sys) disable iff (reset) ce_pix |=> !ce_pix)
		else begin
			fail_count++;
			$error("ce_pix high on two cycles in a row");
		end

	a_slow_single: assert property (@(posedge clk_sys) disable iff (reset) ce_slow |=> !ce_slow)
		else begin
			fail_count++;
			$error("ce_slow high on two cycles in a row");
		end

	// Six quiet cycles after each FM enable
	a_fm_gap: assert property (@(posedge clk_sys) disable iff (reset)
		($past(fm_ce, 1) || $past(fm_ce, 2) || $past(fm_ce, 3) || $past(fm_ce, 4)
		|| $past(fm_ce, 5) || $past(fm_ce, 6)) |-> !fm_ce)
		else begin
			fail_count++;
			$error("fm_ce again within six cycles");
		end

	a_rx_single: assert property (@(posedge clk_sys) disable iff (reset) rx_valid |=> !rx_valid)
		else begin
			fail_count++;
			$error("rx byte strobe longer than one cycle");
		end

	// Reset leaves every strobe and the audio at zero
	a_reset_zero: assert property (@(posedge clk_sys) $past(reset) |->
		!ce_pix && !ce_slow && !fm_ce && !rx_valid && !note_gate && !load_valid
		&& audio_out == 32'd0)
		else begin
			fail_count++;
			$error("output not zero after reset");
		end

endmodule

bind gb_midi_top gb_midi_asserts u_asserts (
	.clk_sys(clk_sys),
	.reset(reset),
	.ce_pix(ce_pix),
	.ce_slow(ce_slow),
	.fm_ce(fm_ce),
	.rx_valid(rx_byte.valid),
	.note_gate(note.gate),
	.load_valid(patch_load.valid),
	.audio_out(audio_out)
);

`default_nettype wire

// ==== verif/gb_midi_tb.sv ====
//**************************************************************************
// Testbench for the MIDI sound core top level. Sends serial MIDI, changes
// the patch menus and feeds FM samples, checking against reference models.
//**************************************************************************
`default_nettype none
`include "gb_midi_settings.svh"

module gb_midi_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int BIT_CLKS = `GBM_UART_PRESCALE * `GBM_UART_OVERSAMPLE;
	// About 40 serial bytes of 10 bits, plus a fifth
	localparam int TIMEOUT_CYCLES = 40 * 10 * BIT_CLKS * 6 / 5;
	localparam logic [7:0] NOTE_ON = {4'h9, `GBM_MIDI_CHANNEL};
	localparam logic [7:0] NOTE_OFF = {4'h8, `GBM_MIDI_CHANNEL};
	localparam logic [7:0] OTHER_ON = {4'h9, `GBM_MIDI_CHANNEL + 4'd1};

	logic clk_sys;
	logic reset;
	logic midi_source_sel;
	logic uart_rxd;
	logic user_rxd;
	logic [2:0] pulse_patch_sel;
	logic [2:0] wave_patch_sel;
	gb_midi_pkg::stereo_sample_t fm_in;
	logic ce_pix;
	logic ce_slow;
	logic fm_ce;
	gb_midi_pkg::note_state_t note;
	gb_midi_pkg::patch_load_t patch_load;
	gb_midi_pkg::stereo_sample_t audio_out;

	int errors;
	int checks;
	int tests;
	int cycles;
	// Compare process inputs
	logic note_req;
	gb_midi_pkg::note_state_t exp_note;
	gb_midi_pkg::stereo_sample_t exp_audio;
	logic [15:0] exp_load;
	// Voice bit on top, then the word
	logic [15:0] load_q[$];
	// Expected state kept by the stimulus
	gb_midi_pkg::note_state_t model_note;
	logic [2:0] cur_pulse;
	logic [2:0] cur_wave;

	gb_midi_top UUT (
		.clk_sys(clk_sys),
		.reset(reset),
		.midi_source_sel(midi_source_sel),
		.uart_rxd(uart_rxd),
		.user_rxd(user_rxd),
		.pulse_patch_sel(pulse_patch_sel),
		.wave_patch_sel(wave_patch_sel),
		.fm_in(fm_in),
		.ce_pix(ce_pix),
		.ce_slow(ce_slow),
		.fm_ce(fm_ce),
		.note(note),
		.patch_load(patch_load),
		.audio_out(audio_out)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#2 clk_sys = ~clk_sys;
		end
	end

	// Note state after one complete message
	function automatic gb_midi_pkg::note_state_t note_ref(
		input gb_midi_pkg::note_state_t cur, input logic [7:0] status,
		input logic [6:0] key, input logic [6:0] vel);
		gb_midi_pkg::note_state_t nxt;
		nxt = cur;
		if (status[3:0] == `GBM_MIDI_CHANNEL) begin
			if (status[7:4] == 4'h9 && vel != 7'd0) begin
				nxt.gate = 1'b1;
				nxt.note = key;
				nxt.velocity = vel;
			end else if (status[7:5] == 3'b100 && key == cur.note) begin
				// Off, or on with zero velocity, for the held note
				nxt.gate = 1'b0;
			end
		end
		return nxt;
	endfunction

	// Preset table, known low where a menu value has no preset
	function automatic logic [14:0] patch_ref(input logic wave, input logic [2:0] sel,
		output logic known);
		logic [14:0] w;
		w = 15'd0;
		known = 1'b1;
		if (!wave) begin
			case (sel)
				3'd0: w = 15'd0;
				3'd1: w = {2'b00, `GBM_PRESET_PULSE_LEAD};
				3'd2: w = {2'b00, `GBM_PRESET_PULSE_PAD};
				3'd3: w = {2'b00, `GBM_PRESET_PULSE_BLIP};
				default: known = 1'b0;
			endcase
		end else begin
			case (sel)
				3'd0: w = 15'd0;
				3'd1: w = `GBM_PRESET_WAVE_LEAD;
				3'd2: w = `GBM_PRESET_WAVE_KICK;
				default: known = 1'b0;
			endcase
		end
		return w;
	endfunction

	// Gain of 22.25 is 89/4 with floor, low 16 bits kept
	function automatic logic [15:0] gain_ref(input logic signed [15:0] s);
		int p;
		p = (int'(s) * 89) >>> 2;
		return p[15:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_mark);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_mark);
	endtask

	// One 8N1 frame, LSB first
	task automatic send_byte(input logic on_user, input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			if (on_user) begin
				user_rxd <= frame[i];
			end else begin
				uart_rxd <= frame[i];
			end
			repeat (BIT_CLKS) @(posedge clk_sys);
		end
	endtask

	// Note state has settled well before the stop bit ends
	task automatic expect_note(input gb_midi_pkg::note_state_t exp);
		exp_note <= exp;
		note_req <= 1'b1;
		@(posedge clk_sys);
		note_req <= 1'b0;
	endtask

	// Status byte is skipped for running status
	task automatic send_msg(input logic on_user, input logic [7:0] status,
		input logic with_status, input logic [6:0] key, input logic [6:0] vel);
		if (with_status) begin
			send_byte(on_user, status);
		end
		send_byte(on_user, {1'b0, key});
		send_byte(on_user, {1'b0, vel});
		model_note = note_ref(model_note, status, key, vel);
		expect_note(model_note);
	endtask

	task automatic set_patch(input logic [2:0] p, input logic [2:0] w);
		logic known;
		logic [14:0] word;
		int wait_cycles;
		// Pulse load queued ahead of wave
		if (p != cur_pulse) begin
			word = patch_ref(1'b0, p, known);
			if (known) begin
				load_q.push_back({1'b0, word});
			end
		end
		if (w != cur_wave) begin
			word = patch_ref(1'b1, w, known);
			if (known) begin
				load_q.push_back({1'b1, word});
			end
		end
		cur_pulse = p;
		cur_wave = w;
		pulse_patch_sel <= p;
		wave_patch_sel <= w;
		wait_cycles = 0;
		while (load_q.size() != 0 && wait_cycles < 8) begin
			@(posedge clk_sys);
			wait_cycles++;
		end
		if (load_q.size() != 0) begin
			errors++;
			$display("patch load missing after menu change to %0d/%0d at %0d ns", p, w, $time);
			load_q.delete();
		end
		// Quiet cycles expose an extra load
		repeat (3) @(posedge clk_sys);
	endtask

	// Compare process, runs every cycle
	always @(posedge clk_sys) begin
		if (reset) begin
			exp_audio <= '0;
		end else begin
			check_value("audio_out", audio_out, exp_audio);
			if (fm_ce) begin
				exp_audio.left <= gain_ref(fm_in.left);
				exp_audio.right <= gain_ref(fm_in.right);
			end
			if (note_req) begin
				check_value("note", 32'(note), 32'(exp_note));
			end
			if (patch_load.valid) begin
				if (load_q.size() == 0) begin
					errors++;
					$display("unexpected patch load at %0d ns, word 0x%0h", $time, patch_load.word);
				end else begin
					exp_load = load_q.pop_front();
					check_value("patch_load.voice", 32'(patch_load.voice), {31'd0, exp_load[15]});
					check_value("patch_load.word", 32'(patch_load.word), {17'd0, exp_load[14:0]});
				end
			end
		end
	end

	// Watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("sim failed");
			$finish;
		end
	end

	initial begin
		int err_mark;
		int wait_cycles;
		int first[3];
		int last[3];
		int div[3];
		string ce_names[3];
		logic [2:0] strobe;
		logic [6:0] key;
		logic [6:0] vel;
		gb_midi_pkg::stereo_sample_t smp;
		void'($urandom(32'hbb7fdcb9));
		reset = 1'b1;
		midi_source_sel = 1'b0;
		uart_rxd = 1'b1;
		user_rxd = 1'b1;
		pulse_patch_sel = 3'd0;
		wave_patch_sel = 3'd0;
		fm_in = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		cycles = 0;
		note_req = 1'b0;
		exp_note = '0;
		model_note = '0;
		cur_pulse = 3'd0;
		cur_wave = 3'd0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;

		// Enable periods, c counts from the first cycle out of reset
		err_mark = errors;
		div = '{`GBM_PIX_DIV, `GBM_SLOW_DIV, `GBM_FM_DIV};
		ce_names = '{"ce_pix", "ce_slow", "fm_ce"};
		first = '{-1, -1, -1};
		last = '{0, 0, 0};
		for (int c = 0; c < 4 * `GBM_SLOW_DIV; c++) begin
			@(posedge clk_sys);
			strobe = {fm_ce, ce_slow, ce_pix};
			for (int k = 0; k < 3; k++) begin
				if (strobe[k]) begin
					if (first[k] < 0) begin
						first[k] = c;
						check_value({ce_names[k], " first delay"}, 32'(c), 32'(div[k]));
					end else begin
						check_value({ce_names[k], " period"}, 32'(c - last[k]), 32'(div[k]));
					end
					last[k] = c;
				end
			end
		end
		for (int k = 0; k < 3; k++) begin
			if (first[k] < 0) begin
				errors++;
				$display("%s never went high after reset", ce_names[k]);
			end
		end
		report_test("clock enables", err_mark);

		// Note on, foreign note off, matching note off
		err_mark = errors;
		key = 7'($urandom % 128);
		vel = 7'(1 + $urandom % 127);
		send_msg(1'b0, NOTE_ON, 1'b1, key, vel);
		send_msg(1'b0, NOTE_OFF, 1'b1, key + 7'd1, 7'h40);
		send_msg(1'b0, NOTE_OFF, 1'b1, key, 7'h40);
		report_test("note on and off", err_mark);

		// Running status, zero velocity, other channel, clock byte
		err_mark = errors;
		send_msg(1'b0, NOTE_ON, 1'b1, 7'($urandom % 128), 7'(1 + $urandom % 127));
		key = 7'($urandom % 128);
		send_msg(1'b0, NOTE_ON, 1'b0, key, 7'(1 + $urandom % 127));
		send_msg(1'b0, NOTE_ON, 1'b0, key, 7'd0);
		send_msg(1'b0, OTHER_ON, 1'b1, 7'($urandom % 128), 7'(1 + $urandom % 127));
		key = 7'($urandom % 128);
		vel = 7'(1 + $urandom % 127);
		send_byte(1'b0, NOTE_ON);
		send_byte(1'b0, {1'b0, key});
		send_byte(1'b0, 8'hF8);
		send_byte(1'b0, {1'b0, vel});
		model_note = note_ref(model_note, NOTE_ON, key, vel);
		expect_note(model_note);
		report_test("parser rules", err_mark);

		// Second pin, first pin must be ignored
		err_mark = errors;
		midi_source_sel <= 1'b1;
		@(posedge clk_sys);
		send_byte(1'b0, NOTE_OFF);
		send_byte(1'b0, {1'b0, model_note.note});
		send_byte(1'b0, 8'h40);
		expect_note(model_note);
		key = 7'($urandom % 128);
		send_msg(1'b1, NOTE_ON, 1'b1, key, 7'(1 + $urandom % 127));
		send_msg(1'b1, NOTE_OFF, 1'b1, key, 7'h40);
		midi_source_sel <= 1'b0;
		@(posedge clk_sys);
		report_test("input select", err_mark);

		// Menu changes, then a tie
		err_mark = errors;
		set_patch(3'd1, 3'd0);
		set_patch(3'd2, 3'd0);
		set_patch(3'd3, 3'd0);
		set_patch(3'd5, 3'd0);
		set_patch(3'd0, 3'd0);
		set_patch(3'd0, 3'd1);
		set_patch(3'd0, 3'd2);
		set_patch(3'd0, 3'd6);
		set_patch(3'd0, 3'd0);
		set_patch(3'd3, 3'd1);
		report_test("patch loads", err_mark);

		// Edge samples first, then random ones
		err_mark = errors;
		for (int i = 0; i < 24; i++) begin
			if (i == 0) begin
				smp.left = 16'h7fff;
				smp.right = 16'h8000;
			end else if (i == 1) begin
				smp.left = 16'hffff;
				smp.right = 16'd1500;
			end else begin
				smp.left = 16'($urandom);
				smp.right = 16'($urandom);
			end
			fm_in <= smp;
			wait_cycles = 0;
			@(posedge clk_sys);
			while (!fm_ce && wait_cycles < 2 * `GBM_FM_DIV) begin
				@(posedge clk_sys);
				wait_cycles++;
			end
			if (!fm_ce) begin
				errors++;
				$display("fm_ce did not arrive for sample %0d", i);
			end
			@(posedge clk_sys);
			check_value("audio_out.left", {16'd0, audio_out.left}, {16'd0, gain_ref(smp.left)});
			check_value("audio_out.right", {16'd0, audio_out.right}, {16'd0, gain_ref(smp.right)});
			// Hold is watched by the compare process
			repeat (3) @(posedge clk_sys);
		end
		report_test("fm gain", err_mark);

		repeat (4) @(posedge clk_sys);
		if (UUT.u_asserts.fail_count != 0) begin
			$display("%0d assertion failures", UUT.u_asserts.fail_count);
			errors += UUT.u_asserts.fail_count;
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/clock_enables.sv ====
//**************************************************************************
// Free-running clock enables: pixel, slow and FM. Each is a one-cycle
// registered strobe, first high one full period after reset.
//**************************************************************************
`default_nettype none
`include "gb_midi_settings.svh"

module clock_enables (
	input wire logic clk_sys,
	input wire logic reset,
	output logic ce_pix,
	output logic ce_slow,
	output logic fm_ce
);

	localparam int PIX_W = $clog2(`GBM_PIX_DIV);
	localparam int SLOW_W = $clog2(`GBM_SLOW_DIV);
	localparam int FM_W = $clog2(`GBM_FM_DIV);

	logic [PIX_W-1:0] pix_cnt;
	logic [SLOW_W-1:0] slow_cnt;
	logic [FM_W-1:0] fm_cnt;

	// Pixel enable, strobe on wrap
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pix_cnt <= '0;
			ce_pix <= 1'b0;
		end else if (pix_cnt == PIX_W'(`GBM_PIX_DIV - 1)) begin
			pix_cnt <= '0;
			ce_pix <= 1'b1;
		end else begin
			pix_cnt <= pix_cnt + 1'b1;
			ce_pix <= 1'b0;
		end
	end

	// Slow enable
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			slow_cnt <= '0;
			ce_slow <= 1'b0;
		end else if (slow_cnt == SLOW_W'(`GBM_SLOW_DIV - 1)) begin
			slow_cnt <= '0;
			ce_slow <= 1'b1;
		end else begin
			slow_cnt <= slow_cnt + 1'b1;
			ce_slow <= 1'b0;
		end
	end

	// FM chip enable, period is not a power of two
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fm_cnt <= '0;
			fm_ce <= 1'b0;
		end else if (fm_cnt == FM_W'(`GBM_FM_DIV - 1)) begin
			fm_cnt <= '0;
			fm_ce <= 1'b1;
		end else begin
			fm_cnt <= fm_cnt + 1'b1;
			fm_ce <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fm_output_stage.sv ====
//**************************************************************************
// FM output gain of 22.25 by shift and add, wrapping at 16 bits.
// Both channels are registered on the FM clock enable.
//**************************************************************************
`default_nettype none
`include "gb_midi_settings.svh"

module fm_output_stage (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic fm_ce,
	input wire gb_midi_pkg::stereo_sample_t fm_in,
	output gb_midi_pkg::stereo_sample_t audio_out
);

	// Sum kept at 16 bits, overflow wraps
	function automatic logic signed [15:0] fm_gain(input logic signed [15:0] s);
		logic signed [15:0] sum;
		sum = (s <<< `GBM_FM_SHL_A) + (s <<< `GBM_FM_SHL_B)
			+ (s <<< `GBM_FM_SHL_C) + (s >>> `GBM_FM_SHR_D);
		return sum;
	endfunction

	// Holds between enables
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out <= '0;
		end else if (fm_ce) begin
			audio_out.left <= fm_gain(fm_in.left);
			audio_out.right <= fm_gain(fm_in.right);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/gb_midi_pkg.sv ====
//**************************************************************************
// Shared types of the MIDI sound core: received bytes, note state,
// patch words with their two decodings, and stereo samples
//**************************************************************************
`default_nettype none

package gb_midi_pkg;

	// One received MIDI byte, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic [7:0] data;
	} midi_byte_t;

	// Held note of the parsed channel
	typedef struct packed {
		logic gate;
		logic [6:0] note;
		logic [6:0] velocity;
	} note_state_t;

	typedef enum logic {
		voice_pulse = 1'b0,
		voice_wave = 1'b1
	} patch_voice_e;

	// Pulse voice decoding, top bits unused
	typedef struct packed {
		logic [1:0] pad;
		logic blip;
		logic echo;
		logic auto_duty;
		logic vibrato;
		logic mod_duty;
		logic [3:0] fade_speed;
		logic fade_en;
		logic auto_poly;
		logic [1:0] duty;
	} pulse_view_t;

	// Wave voice decoding
	typedef struct packed {
		logic [3:0] fade_speed;
		logic fade_en;
		logic [2:0] fall_speed;
		logic fall_en;
		logic blip;
		logic vibrato;
		logic [3:0] waveform;
	} wave_view_t;

	// Same 15-bit word, read by voice type
	typedef union packed {
		pulse_view_t pulse;
		wave_view_t wave;
	} patch_word_u;

	typedef struct packed {
		logic valid;
		patch_voice_e voice;
		patch_word_u word;
	} patch_load_t;

	typedef struct packed {
		logic signed [15:0] left;
		logic signed [15:0] right;
	} stereo_sample_t;

endpackage

`default_nettype wire

// ==== verilog/gb_midi_settings.svh ====
//**************************************************************************
// Tunable constants of the MIDI sound core: serial timing, MIDI channel,
// clock-enable periods, FM gain shifts and the patch preset words.
// Include in every module that needs one of them.
//**************************************************************************
`ifndef GB_MIDI_SETTINGS_SVH
`define GB_MIDI_SETTINGS_SVH

// Serial timing, one bit lasts PRESCALE * OVERSAMPLE clocks (1720)
`define GBM_UART_PRESCALE 215
`define GBM_UART_OVERSAMPLE 8

// Note messages are accepted on this channel only
`define GBM_MIDI_CHANNEL 4'd0

// Enable periods in clk_sys cycles
`define GBM_PIX_DIV 4
`define GBM_SLOW_DIV 16
`define GBM_FM_DIV 7

// FM gain, 16 + 4 + 2 + 1/4 = 22.25
`define GBM_FM_SHL_A 4
`define GBM_FM_SHL_B 2
`define GBM_FM_SHL_C 1
`define GBM_FM_SHR_D 2

// Pulse presets, blip bit down to duty
`define GBM_PRESET_PULSE_LEAD 13'b0111000011000
`define GBM_PRESET_PULSE_PAD 13'b0000000011101
`define GBM_PRESET_PULSE_BLIP 13'b1100010011010

// Wave presets, fade speed down to waveform
`define GBM_PRESET_WAVE_LEAD 15'b000010000010001
`define GBM_PRESET_WAVE_KICK 15'b010011011000100

`endif

// ==== verilog/gb_midi_top.sv ====
//**************************************************************************
// Top level of the MIDI sound core. Wires the clock enables, the serial
// receiver, the note parser, the preset loader and the FM gain stage.
//**************************************************************************
`default_nettype none

module gb_midi_top (
	input wire logic clk_sys,
	input wire logic reset,
	// 0 takes uart_rxd, 1 takes user_rxd
	input wire logic midi_source_sel,
	input wire logic uart_rxd,
	input wire logic user_rxd,
	input wire logic [2:0] pulse_patch_sel,
	input wire logic [2:0] wave_patch_sel,
	// Sample from the FM synthesizer
	input wire gb_midi_pkg::stereo_sample_t fm_in,
	output logic ce_pix,
	output logic ce_slow,
	output logic fm_ce,
	output gb_midi_pkg::note_state_t note,
	output gb_midi_pkg::patch_load_t patch_load,
	output gb_midi_pkg::stereo_sample_t audio_out
);

	// Receiver to parser byte strobe
	gb_midi_pkg::midi_byte_t rx_byte;

	clock_enables u_clock_enables (
		.clk_sys(clk_sys),
		.reset(reset),
		.ce_pix(ce_pix),
		.ce_slow(ce_slow),
		.fm_ce(fm_ce)
	);

	midi_uart_rx u_midi_uart_rx (
		.clk_sys(clk_sys),
		.reset(reset),
		.source_sel(midi_source_sel),
		.uart_rxd(uart_rxd),
		.user_rxd(user_rxd),
		.rx_byte(rx_byte)
	);

	midi_note_parser u_midi_note_parser (
		.clk_sys(clk_sys),
		.reset(reset),
		.rx_byte(rx_byte),
		.note(note)
	);

	patch_preset_loader u_patch_preset_loader (
		.clk_sys(clk_sys),
		.reset(reset),
		.pulse_patch_sel(pulse_patch_sel),
		.wave_patch_sel(wave_patch_sel),
		.patch_load(patch_load)
	);

	// Gain stage runs on the FM enable
	fm_output_stage u_fm_output_stage (
		.clk_sys(clk_sys),
		.reset(reset),
		.fm_ce(fm_ce),
		.fm_in(fm_in),
		.audio_out(audio_out)
	);

endmodule

`default_nettype wire

// ==== verilog/midi_note_parser.sv ====
//**************************************************************************
// Note-on / note-off parser for one MIDI channel with running status.
// Feeds the held note, its velocity and a gate to the sound voices.
//**************************************************************************
`default_nettype none
`include "gb_midi_settings.svh"

module midi_note_parser (
	input wire logic clk_sys,
	input wire logic reset,
	input wire gb_midi_pkg::midi_byte_t rx_byte,
	output gb_midi_pkg::note_state_t note
);

	logic run_valid;
	// 1 for note-on, 0 for note-off
	logic run_on;
	logic data_idx;
	logic [6:0] first_data;
	logic is_status;
	logic is_realtime;
	logic our_note_msg;
	logic pair_done;
	logic note_start;
	logic note_stop;

	assign is_status = rx_byte.valid && rx_byte.data[7];
	// Clock and other real-time bytes pass through untouched
	assign is_realtime = rx_byte.data >= 8'hF8;
	assign our_note_msg = (rx_byte.data[7:5] == 3'b100)
		&& (rx_byte.data[3:0] == `GBM_MIDI_CHANNEL);

	// Second data byte completes a message
	assign pair_done = rx_byte.valid && !rx_byte.data[7] && run_valid && data_idx;
	assign note_start = pair_done && run_on && (rx_byte.data[6:0] != 7'd0);
	// Velocity 0 note-on counts as note-off
	assign note_stop = pair_done && !note_start && (first_data == note.note);

	// Running status and byte position
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			run_valid <= 1'b0;
			run_on <= 1'b0;
			data_idx <= 1'b0;
		end else if (is_status && !is_realtime) begin
			run_valid <= our_note_msg;
			run_on <= rx_byte.data[4];
			data_idx <= 1'b0;
		end else if (rx_byte.valid && !rx_byte.data[7] && run_valid) begin
			data_idx <= !data_idx;
		end
	end

	// Note number is held until the velocity arrives
	always_ff @(posedge clk_sys) begin
		if (rx_byte.valid && !rx_byte.data[7] && run_valid && !data_idx) begin
			first_data <= rx_byte.data[6:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			note.gate <= 1'b0;
		end else if (note_start) begin
			note.gate <= 1'b1;
		end else if (note_stop) begin
			note.gate <= 1'b0;
		end
	end

	// Pitch and velocity change only on a new note
	always_ff @(posedge clk_sys) begin
		if (note_start) begin
			note.note <= first_data;
			note.velocity <= rx_byte.data[6:0];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/midi_uart_rx.sv ====
//**************************************************************************
// MIDI serial receiver, 8N1 at 31,250 baud. Picks one of two pins,
// synchronizes it and strobes each good byte for one cycle.
//**************************************************************************
`default_nettype none
`include "gb_midi_settings.svh"

module midi_uart_rx (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic source_sel,
	input wire logic uart_rxd,
	input wire logic user_rxd,
	output gb_midi_pkg::midi_byte_t rx_byte
);

	localparam int PRE_W = $clog2(`GBM_UART_PRESCALE);
	localparam int OS_W = $clog2(`GBM_UART_OVERSAMPLE);

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_e;

	rx_state_e state;
	logic rx_meta;
	logic rx_sync;
	logic rx_last;
	logic [PRE_W-1:0] pre_cnt;
	logic [OS_W-1:0] os_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic tick;
	logic start_edge;
	logic stop_ok;

	// Two-flop synchronizer, idle line is high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_last <= 1'b1;
		end else begin
			rx_meta <= source_sel ? user_rxd : uart_rxd;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
		end
	end

	assign start_edge = rx_last && !rx_sync;
	assign tick = (pre_cnt == PRE_W'(`GBM_UART_PRESCALE - 1));
	// Stop bit sampled high at its middle
	assign stop_ok = (state == st_stop) && tick
		&& (os_cnt == OS_W'(`GBM_UART_OVERSAMPLE - 1)) && rx_sync;

	// Prescaler restarts with every frame
	always_ff @(posedge clk_sys) begin
		if (reset || state == st_idle || tick) begin
			pre_cnt <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	// Frame FSM, counts oversample ticks per bit
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
			os_cnt <= '0;
			bit_cnt <= '0;
			rx_byte.valid <= 1'b0;
		end else begin
			rx_byte.valid <= stop_ok;
			case (state)
				st_idle: begin
					os_cnt <= '0;
					bit_cnt <= '0;
					if (start_edge) begin
						state <= st_start;
					end
				end
				st_start: if (tick) begin
					// Half a bit in, a glitch returns to idle
					if (os_cnt == OS_W'(`GBM_UART_OVERSAMPLE / 2 - 1)) begin
						os_cnt <= '0;
						state <= rx_sync ? st_idle : st_data;
					end else begin
						os_cnt <= os_cnt + 1'b1;
					end
				end
				st_data: if (tick) begin
					os_cnt <= os_cnt + 1'b1;
					if (os_cnt == OS_W'(`GBM_UART_OVERSAMPLE - 1)) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) begin
							state <= st_stop;
						end
					end
				end
				default: if (tick) begin
					// Bad stop bit drops the byte
					os_cnt <= os_cnt + 1'b1;
					if (os_cnt == OS_W'(`GBM_UART_OVERSAMPLE - 1)) begin
						state <= st_idle;
					end
				end
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge clk_sys) begin
		if (state == st_data && tick && os_cnt == OS_W'(`GBM_UART_OVERSAMPLE - 1)) begin
			shift <= {rx_sync, shift[7:1]};
		end
		if (stop_ok) begin
			rx_byte.data <= shift;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/patch_preset_loader.sv ====
//**************************************************************************
// Turns patch menu changes into one-cycle preset loads. The pulse voice
// wins a tie; the wave change then loads on the next cycle.
//**************************************************************************
`default_nettype none
`include "gb_midi_settings.svh"

module patch_preset_loader (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic [2:0] pulse_patch_sel,
	input wire logic [2:0] wave_patch_sel,
	output gb_midi_pkg::patch_load_t patch_load
);

	logic [2:0] pulse_last;
	logic [2:0] wave_last;
	logic pulse_change;
	logic wave_change;
	logic pulse_known;
	logic wave_known;
	gb_midi_pkg::patch_word_u pulse_word;
	gb_midi_pkg::patch_word_u wave_word;

	assign pulse_change = (pulse_patch_sel != pulse_last);
	// Wave waits while a pulse change is pending
	assign wave_change = !pulse_change && (wave_patch_sel != wave_last);

	// Pulse table, top two bits stay clear
	always_comb begin
		pulse_word = '0;
		pulse_known = 1'b1;
		case (pulse_patch_sel)
			3'd0: pulse_word = '0;
			3'd1: pulse_word.pulse = {2'b00, `GBM_PRESET_PULSE_LEAD};
			3'd2: pulse_word.pulse = {2'b00, `GBM_PRESET_PULSE_PAD};
			3'd3: pulse_word.pulse = {2'b00, `GBM_PRESET_PULSE_BLIP};
			default: pulse_known = 1'b0;
		endcase
	end

	// Wave table
	always_comb begin
		wave_word = '0;
		wave_known = 1'b1;
		case (wave_patch_sel)
			3'd0: wave_word = '0;
			3'd1: wave_word.wave = `GBM_PRESET_WAVE_LEAD;
			3'd2: wave_word.wave = `GBM_PRESET_WAVE_KICK;
			default: wave_known = 1'b0;
		endcase
	end

	// Last seen selections, zero so a first pick loads
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pulse_last <= 3'd0;
			wave_last <= 3'd0;
			patch_load.valid <= 1'b0;
		end else begin
			patch_load.valid <= (pulse_change && pulse_known) || (wave_change && wave_known);
			if (pulse_change) begin
				pulse_last <= pulse_patch_sel;
			end
			if (wave_change) begin
				wave_last <= wave_patch_sel;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (pulse_change) begin
			patch_load.voice <= gb_midi_pkg::voice_pulse;
			patch_load.word <= pulse_word;
		end else if (wave_change) begin
			patch_load.voice <= gb_midi_pkg::voice_wave;
			patch_load.word <= wave_word;
		end
	end

endmodule

`default_nettype wire
